/* include/dcache_config.svh */
// sizes and widths of the data cache
// base values plus the widths derived from them
`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// requesters and core tag
`define DC_NUM_REQS        2
`define DC_TAG_WIDTH       4
`define DC_SRC_BITS        $clog2(`DC_NUM_REQS)

// word and line geometry
`define DC_WORD_BYTES      4
`define DC_WORD_BITS       (`DC_WORD_BYTES * 8)
`define DC_LINE_WORDS      4
`define DC_LINE_BITS       (`DC_WORD_BITS * `DC_LINE_WORDS)
`define DC_WSEL_BITS       $clog2(`DC_LINE_WORDS)

// sets, ways and address split
`define DC_SETS            16
`define DC_WAYS            2
`define DC_SET_BITS        $clog2(`DC_SETS)
`define DC_ADDR_WIDTH      16
`define DC_LINE_ADDR_WIDTH (`DC_ADDR_WIDTH - `DC_WSEL_BITS)
`define DC_CTAG_BITS       (`DC_LINE_ADDR_WIDTH - `DC_SET_BITS)

// event counters and bench memory latency
`define DC_PERF_BITS       16
`define DC_MEM_DELAY       3

`endif

/* design/dcache_pkg.sv */
// data cache types
// words, lines, core requests and responses, memory requests
`include "dcache_config.svh"
`default_nettype none

package dcache_pkg;

    typedef logic [`DC_WORD_BITS-1:0]  word_t;
    typedef logic [`DC_WORD_BYTES-1:0] byteen_t;
    typedef logic [`DC_LINE_BITS-1:0]  line_t;
    typedef logic [`DC_ADDR_WIDTH-1:0] waddr_t;
    typedef logic [`DC_SRC_BITS-1:0]   src_t;

    // word request from one core port
    typedef struct packed {
        waddr_t                   addr;
        logic                     rw;
        byteen_t                  byteen;
        word_t                    data;
        logic [`DC_TAG_WIDTH-1:0] tag;
    } core_req_t;

    // request after arbitration, source kept for the response
    typedef struct packed {
        core_req_t req;
        src_t      src;
    } core_req_src_t;

    typedef struct packed {
        word_t                    data;
        logic [`DC_TAG_WIDTH-1:0] tag;
    } core_rsp_t;

    // line read or single word write toward memory
    typedef struct packed {
        logic [`DC_LINE_ADDR_WIDTH-1:0] line_addr;
        logic                           we;
        logic [`DC_WSEL_BITS-1:0]       wsel;
        byteen_t                        byteen;
        word_t                          data;
    } mem_req_t;

endpackage

`default_nettype wire

/* design/elastic_buffer.sv */
// two-entry valid/ready buffer
// payload type is a parameter, input ready comes from occupancy only
`timescale 1ns/1ns
`default_nettype none

module elastic_buffer #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     in_valid_i,
    input  payload_t in_data_i,
    output logic     in_ready_o,
    output logic     out_valid_o,
    output payload_t out_data_o,
    input  logic     out_ready_i
);

    // storage slots
    payload_t   mem_q [2];
    logic       wr_ptr_q;
    logic       rd_ptr_q;
    logic [1:0] count_q;
    logic       push;
    logic       pop;

    assign in_ready_o  = (count_q != 2'd2);
    assign out_valid_o = (count_q != 2'd0);
    assign out_data_o  = mem_q[rd_ptr_q];

    assign push = in_valid_i && in_ready_o;
    assign pop  = out_valid_o && out_ready_i;

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            count_q  <= 2'd0;
        end else begin
            if (push) wr_ptr_q <= ~wr_ptr_q;
            if (pop) rd_ptr_q <= ~rd_ptr_q;
            // simultaneous push and pop keeps the count
            count_q <= count_q + 2'(push) - 2'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem_q[wr_ptr_q] <= in_data_i;
    end

    // occupancy bounded over any push/pop sequence
    a_max_two: assert property (@(posedge clk) disable iff (reset) count_q <= 2'd2);

endmodule

`default_nettype wire

/* design/req_arbiter.sv */
// round-robin arbiter over the buffered core requests
// attaches the winning port index as source
`include "dcache_config.svh"
`timescale 1ns/1ns
`default_nettype none

module req_arbiter import dcache_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  logic          req_valid_i [`DC_NUM_REQS],
    input  core_req_t     req_i [`DC_NUM_REQS],
    output logic          req_ready_o [`DC_NUM_REQS],
    output logic          grant_valid_o,
    output core_req_src_t grant_o,
    input  logic          grant_ready_i
);

    // next port to get priority
    src_t                   ptr_q;
    src_t                   sel;
    logic                   found;
    logic [`DC_NUM_REQS-1:0] ready_vec;

    // first valid port at or after the pointer
    always_comb begin
        src_t idx;
        sel   = ptr_q;
        found = 1'b0;
        for (int i = 0; i < `DC_NUM_REQS; i++) begin
            idx = src_t'((int'(ptr_q) + i) % `DC_NUM_REQS);
            if (!found && req_valid_i[idx]) begin
                found = 1'b1;
                sel   = idx;
            end
        end
    end

    assign grant_valid_o = found;
    assign grant_o       = '{req: req_i[sel], src: sel};

    // ready only toward the chosen port
    for (genvar p = 0; p < `DC_NUM_REQS; p++) begin : g_ready
        assign ready_vec[p]   = grant_ready_i && found && (sel == src_t'(p));
        assign req_ready_o[p] = ready_vec[p];
    end

    // pointer moves past the winner once it transfers
    always_ff @(posedge clk) begin
        if (reset) begin
            ptr_q <= '0;
        end else if (found && grant_ready_i) begin
            ptr_q <= src_t'((int'(sel) + 1) % `DC_NUM_REQS);
        end
    end

    a_one_ready: assert property (@(posedge clk) disable iff (reset) $onehot0(ready_vec));

endmodule

`default_nettype wire

/* design/cache_core.sv */
// 2-way set-associative lookup pipeline
// lookup stage, response stage, single line refill, write-through
// response routed to the issuing port, event pulses for the counters
`include "dcache_config.svh"
`timescale 1ns/1ns
`default_nettype none

module cache_core import dcache_pkg::*; (
    input  logic          clk,
    input  logic          reset,
    input  logic          req_valid_i,
    input  core_req_src_t req_i,
    output logic          req_ready_o,
    output logic          mem_req_valid_o,
    output mem_req_t      mem_req_o,
    input  logic          mem_req_ready_i,
    input  logic          mem_rsp_valid_i,
    input  line_t         mem_rsp_line_i,
    output logic          rsp_valid_o [`DC_NUM_REQS],
    output core_rsp_t     rsp_o,
    output logic          evt_read_o,
    output logic          evt_write_o,
    output logic          evt_read_miss_o,
    output logic          evt_write_miss_o
);

    localparam int WAY_BITS = $clog2(`DC_WAYS);

    // tag and data arrays, per-set valid bits and victim pointer
    logic [`DC_WAYS-1:0]       valid_q [`DC_SETS];
    logic [`DC_CTAG_BITS-1:0]  tag_q [`DC_SETS][`DC_WAYS];
    line_t                     data_q [`DC_SETS][`DC_WAYS];
    logic [WAY_BITS-1:0]       victim_q [`DC_SETS];

    // lookup stage
    logic                      s1_valid_q;
    core_req_src_t             s1_req_q;
    logic                      refill_pend_q;

    // response stage
    logic                      rsp_valid_q;
    src_t                      rsp_src_q;
    core_rsp_t                 rsp_q;

    logic [`DC_WSEL_BITS-1:0]  s1_wsel;
    logic [`DC_SET_BITS-1:0]   s1_set;
    logic [`DC_CTAG_BITS-1:0]  s1_tag;
    logic [`DC_WAYS-1:0]       hit_way;
    logic                      hit;
    logic [WAY_BITS-1:0]       hit_idx;
    logic                      s1_rd;
    logic                      s1_wr;
    logic                      refill_done;
    logic                      s1_fire;
    logic                      accept;
    word_t                     hit_word;
    word_t                     fill_word;
    word_t                     merged_word;
    logic [`DC_NUM_REQS-1:0]   rsp_vec;

    // word address split into word select, set and tag
    assign s1_wsel = s1_req_q.req.addr[`DC_WSEL_BITS-1:0];
    assign s1_set  = s1_req_q.req.addr[`DC_WSEL_BITS +: `DC_SET_BITS];
    assign s1_tag  = s1_req_q.req.addr[`DC_ADDR_WIDTH-1 -: `DC_CTAG_BITS];

    // compare both ways
    always_comb begin
        hit_idx = '0;
        for (int w = 0; w < `DC_WAYS; w++) begin
            hit_way[w] = valid_q[s1_set][w] && (tag_q[s1_set][w] == s1_tag);
            if (hit_way[w]) hit_idx = WAY_BITS'(w);
        end
    end
    assign hit = |hit_way;

    assign hit_word  = data_q[s1_set][hit_idx][s1_wsel*`DC_WORD_BITS +: `DC_WORD_BITS];
    assign fill_word = mem_rsp_line_i[s1_wsel*`DC_WORD_BITS +: `DC_WORD_BITS];

    // store bytes over the cached word
    always_comb begin
        for (int b = 0; b < `DC_WORD_BYTES; b++) begin
            merged_word[b*8 +: 8] = s1_req_q.req.byteen[b] ? s1_req_q.req.data[b*8 +: 8]
                                                           : hit_word[b*8 +: 8];
        end
    end

    assign s1_rd       = s1_valid_q && !s1_req_q.req.rw;
    assign s1_wr       = s1_valid_q && s1_req_q.req.rw;
    assign refill_done = refill_pend_q && mem_rsp_valid_i;

    // lookup stage retires on a read hit, an accepted write or the refill line
    assign s1_fire     = (s1_rd && hit) || (s1_wr && mem_req_ready_i) || refill_done;
    assign req_ready_o = !s1_valid_q || s1_fire;
    assign accept      = req_valid_i && req_ready_o;

    // every write goes out, a read miss asks once for the line
    assign mem_req_valid_o     = s1_wr || (s1_rd && !hit && !refill_pend_q);
    assign mem_req_o.line_addr = s1_req_q.req.addr[`DC_ADDR_WIDTH-1:`DC_WSEL_BITS];
    assign mem_req_o.we        = s1_req_q.req.rw;
    assign mem_req_o.wsel      = s1_wsel;
    assign mem_req_o.byteen    = s1_req_q.req.byteen;
    assign mem_req_o.data      = s1_req_q.req.data;

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid_q    <= 1'b0;
            refill_pend_q <= 1'b0;
            rsp_valid_q   <= 1'b0;
            for (int s = 0; s < `DC_SETS; s++) begin
                valid_q[s]  <= '0;
                victim_q[s] <= '0;
            end
        end else begin
            if (accept) begin
                s1_valid_q <= 1'b1;
            end else if (s1_fire) begin
                s1_valid_q <= 1'b0;
            end
            if (s1_rd && !hit && !refill_pend_q && mem_req_ready_i) begin
                refill_pend_q <= 1'b1;
            end else if (mem_rsp_valid_i) begin
                refill_pend_q <= 1'b0;
            end
            rsp_valid_q <= s1_fire;
            // fill the victim way, then rotate the set's pointer
            if (refill_done) begin
                valid_q[s1_set][victim_q[s1_set]] <= 1'b1;
                victim_q[s1_set] <= victim_q[s1_set] + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) s1_req_q <= req_i;
        if (refill_done) begin
            tag_q[s1_set][victim_q[s1_set]]  <= s1_tag;
            data_q[s1_set][victim_q[s1_set]] <= mem_rsp_line_i;
        end
        // write hit updates the line, write miss leaves the arrays alone
        if (s1_wr && mem_req_ready_i && hit) begin
            data_q[s1_set][hit_idx][s1_wsel*`DC_WORD_BITS +: `DC_WORD_BITS] <= merged_word;
        end
        if (s1_fire) begin
            rsp_src_q <= s1_req_q.src;
            rsp_q.tag <= s1_req_q.req.tag;
            if (s1_wr) begin
                rsp_q.data <= '0;
            end else if (refill_done) begin
                rsp_q.data <= fill_word;
            end else begin
                rsp_q.data <= hit_word;
            end
        end
    end

    // route the response to its source port
    for (genvar p = 0; p < `DC_NUM_REQS; p++) begin : g_rsp
        assign rsp_vec[p]     = rsp_valid_q && (rsp_src_q == src_t'(p));
        assign rsp_valid_o[p] = rsp_vec[p];
    end
    assign rsp_o = rsp_q;

    // requests count on acceptance, misses when the lookup retires
    assign evt_read_o       = accept && !req_i.req.rw;
    assign evt_write_o      = accept && req_i.req.rw;
    assign evt_read_miss_o  = s1_fire && s1_rd && !hit;
    assign evt_write_miss_o = s1_fire && s1_wr && !hit;

    // memory side answers only the refill it was asked for
    a_rsp_pending: assert property (@(posedge clk) disable iff (reset)
        mem_rsp_valid_i |-> refill_pend_q);
    a_one_rsp: assert property (@(posedge clk) disable iff (reset) $onehot0(rsp_vec));

endmodule

`default_nettype wire

/* design/perf_counters.sv */
// read, write, read-miss and write-miss counters
// wrap around at full scale
`include "dcache_config.svh"
`timescale 1ns/1ns
`default_nettype none

module perf_counters (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     evt_read_i,
    input  logic                     evt_write_i,
    input  logic                     evt_read_miss_i,
    input  logic                     evt_write_miss_i,
    output logic [`DC_PERF_BITS-1:0] perf_reads_o,
    output logic [`DC_PERF_BITS-1:0] perf_writes_o,
    output logic [`DC_PERF_BITS-1:0] perf_read_misses_o,
    output logic [`DC_PERF_BITS-1:0] perf_write_misses_o
);

    logic [3:0]               evt;
    logic [`DC_PERF_BITS-1:0] cnt_q [4];

    // one slot per event, same order as the outputs
    assign evt = {evt_write_miss_i, evt_read_miss_i, evt_write_i, evt_read_i};

    always_ff @(posedge clk) begin
        for (int i = 0; i < 4; i++) begin
            if (reset) begin
                cnt_q[i] <= '0;
            end else if (evt[i]) begin
                cnt_q[i] <= cnt_q[i] + 1'b1;
            end
        end
    end

    assign perf_reads_o        = cnt_q[0];
    assign perf_writes_o       = cnt_q[1];
    assign perf_read_misses_o  = cnt_q[2];
    assign perf_write_misses_o = cnt_q[3];

endmodule

`default_nettype wire

/* design/dcache_top.sv */
// data cache top level
// per-port request buffers, arbiter, cache core, memory request buffer, counters
`include "dcache_config.svh"
`timescale 1ns/1ns
`default_nettype none

module dcache_top import dcache_pkg::*; (
    input  logic                     clk,
    input  logic                     reset,
    // core side
    input  logic                     core_req_valid_i [`DC_NUM_REQS],
    output logic                     core_req_ready_o [`DC_NUM_REQS],
    input  core_req_t                core_req_i [`DC_NUM_REQS],
    output logic                     core_rsp_valid_o [`DC_NUM_REQS],
    output core_rsp_t                core_rsp_o,
    // memory side
    output logic                     mem_req_valid_o,
    input  logic                     mem_req_ready_i,
    output mem_req_t                 mem_req_o,
    input  logic                     mem_rsp_valid_i,
    input  line_t                    mem_rsp_line_i,
    // counters
    output logic [`DC_PERF_BITS-1:0] perf_reads_o,
    output logic [`DC_PERF_BITS-1:0] perf_writes_o,
    output logic [`DC_PERF_BITS-1:0] perf_read_misses_o,
    output logic [`DC_PERF_BITS-1:0] perf_write_misses_o
);

    // buffered requests toward the arbiter
    logic          buf_valid [`DC_NUM_REQS];
    logic          buf_ready [`DC_NUM_REQS];
    core_req_t     buf_data [`DC_NUM_REQS];

    // arbiter to core
    logic          grant_valid;
    logic          grant_ready;
    core_req_src_t grant;

    // core to memory buffer
    logic          mreq_valid;
    logic          mreq_ready;
    mem_req_t      mreq;

    logic          evt_read;
    logic          evt_write;
    logic          evt_read_miss;
    logic          evt_write_miss;

    for (genvar p = 0; p < `DC_NUM_REQS; p++) begin : g_req_buf
        elastic_buffer #(
            .payload_t (core_req_t)
        ) req_buf (
            .clk         (clk),
            .reset       (reset),
            .in_valid_i  (core_req_valid_i[p]),
            .in_data_i   (core_req_i[p]),
            .in_ready_o  (core_req_ready_o[p]),
            .out_valid_o (buf_valid[p]),
            .out_data_o  (buf_data[p]),
            .out_ready_i (buf_ready[p])
        );
    end

    req_arbiter arb (
        .clk           (clk),
        .reset         (reset),
        .req_valid_i   (buf_valid),
        .req_i         (buf_data),
        .req_ready_o   (buf_ready),
        .grant_valid_o (grant_valid),
        .grant_o       (grant),
        .grant_ready_i (grant_ready)
    );

    cache_core core (
        .clk              (clk),
        .reset            (reset),
        .req_valid_i      (grant_valid),
        .req_i            (grant),
        .req_ready_o      (grant_ready),
        .mem_req_valid_o  (mreq_valid),
        .mem_req_o        (mreq),
        .mem_req_ready_i  (mreq_ready),
        .mem_rsp_valid_i  (mem_rsp_valid_i),
        .mem_rsp_line_i   (mem_rsp_line_i),
        .rsp_valid_o      (core_rsp_valid_o),
        .rsp_o            (core_rsp_o),
        .evt_read_o       (evt_read),
        .evt_write_o      (evt_write),
        .evt_read_miss_o  (evt_read_miss),
        .evt_write_miss_o (evt_write_miss)
    );

    // memory request buffer, absorbs memory back-pressure
    elastic_buffer #(
        .payload_t (mem_req_t)
    ) mem_buf (
        .clk         (clk),
        .reset       (reset),
        .in_valid_i  (mreq_valid),
        .in_data_i   (mreq),
        .in_ready_o  (mreq_ready),
        .out_valid_o (mem_req_valid_o),
        .out_data_o  (mem_req_o),
        .out_ready_i (mem_req_ready_i)
    );

    perf_counters perf (
        .clk                 (clk),
        .reset               (reset),
        .evt_read_i          (evt_read),
        .evt_write_i         (evt_write),
        .evt_read_miss_i     (evt_read_miss),
        .evt_write_miss_i    (evt_write_miss),
        .perf_reads_o        (perf_reads_o),
        .perf_writes_o       (perf_writes_o),
        .perf_read_misses_o  (perf_read_misses_o),
        .perf_write_misses_o (perf_write_misses_o)
    );

endmodule

`default_nettype wire

/* bench/mem_model.sv */
// behavioral line memory for the data cache bench
// byte-enabled word writes, line reads after a fixed delay
// random request back-pressure from a seeded $random
`include "dcache_config.svh"
`timescale 1ns/1ns
`default_nettype none

module mem_model import dcache_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     mem_req_valid_i,
    input  mem_req_t mem_req_i,
    output logic     mem_req_ready_o,
    output logic     mem_rsp_valid_o,
    output line_t    mem_rsp_line_o
);

    localparam int LINES = 1 << `DC_LINE_ADDR_WIDTH;

    line_t                          mem_q [LINES];
    integer                         seed;
    int                             delay_cnt;
    logic [`DC_LINE_ADDR_WIDTH-1:0] rd_addr;

    // word address a holds a ^ 32'h5a5a0000
    initial begin
        seed            = 32'h5596f22f;
        delay_cnt       = 0;
        rd_addr         = '0;
        mem_req_ready_o = 1'b0;
        mem_rsp_valid_o = 1'b0;
        mem_rsp_line_o  = '0;
        for (int l = 0; l < LINES; l++) begin
            for (int w = 0; w < `DC_LINE_WORDS; w++) begin
                mem_q[l][w*`DC_WORD_BITS +: `DC_WORD_BITS] =
                    word_t'(l * `DC_LINE_WORDS + w) ^ 32'h5a5a0000;
            end
        end
    end

    // merge the enabled bytes into the stored line
    task automatic write_word(input mem_req_t req);
        line_t line;
        int    base;
        line = mem_q[req.line_addr];
        base = int'(req.wsel) * `DC_WORD_BITS;
        for (int b = 0; b < `DC_WORD_BYTES; b++) begin
            if (req.byteen[b]) line[base + b*8 +: 8] = req.data[b*8 +: 8];
        end
        mem_q[req.line_addr] = line;
    endtask

    // outputs change 1 ns after the edge, handshake seen for the whole cycle
    always @(posedge clk) begin
        #1;
        if (reset) begin
            mem_req_ready_o = 1'b0;
            mem_rsp_valid_o = 1'b0;
            delay_cnt       = 0;
        end else begin
            mem_rsp_valid_o = 1'b0;
            // line goes out when the delay runs down
            if (delay_cnt > 0) begin
                delay_cnt = delay_cnt - 1;
                if (delay_cnt == 0) begin
                    mem_rsp_valid_o = 1'b1;
                    mem_rsp_line_o  = mem_q[rd_addr];
                end
            end
            // ready about three cycles in four
            mem_req_ready_o = (($random(seed) & 3) != 0);
            if (mem_req_ready_o && mem_req_valid_i) begin
                if (mem_req_i.we) begin
                    write_word(mem_req_i);
                end else begin
                    rd_addr   = mem_req_i.line_addr;
                    delay_cnt = `DC_MEM_DELAY;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* bench/dcache_tb.sv */
// testbench for the data cache
// request table with expected data from a shadow memory
// per-port request tasks, counter checks, write-through check, summary
`include "dcache_config.svh"
`timescale 1ns/1ns
`default_nettype none

module dcache_tb import dcache_pkg::*; ();

    localparam int TIMEOUT     = 200;
    localparam int NUM_ENTRIES = 16;
    localparam int NUM_WORDS   = 1 << `DC_ADDR_WIDTH;

    // one table row, pair issues this row and the next one together
    typedef struct packed {
        src_t                     port;
        logic                     rw;
        waddr_t                   addr;
        byteen_t                  be;
        word_t                    data;
        logic [`DC_TAG_WIDTH-1:0] tag;
        logic                     miss;
        logic                     pair;
    } entry_t;

    logic                     clk;
    logic                     reset;
    logic                     core_req_valid [`DC_NUM_REQS];
    logic                     core_req_ready [`DC_NUM_REQS];
    core_req_t                core_req [`DC_NUM_REQS];
    logic                     core_rsp_valid [`DC_NUM_REQS];
    core_rsp_t                core_rsp;
    logic                     mem_req_valid;
    logic                     mem_req_ready;
    mem_req_t                 mem_req;
    logic                     mem_rsp_valid;
    line_t                    mem_rsp_line;
    logic [`DC_PERF_BITS-1:0] perf_reads;
    logic [`DC_PERF_BITS-1:0] perf_writes;
    logic [`DC_PERF_BITS-1:0] perf_read_misses;
    logic [`DC_PERF_BITS-1:0] perf_write_misses;

    entry_t tbl [NUM_ENTRIES];
    word_t  exp_data [NUM_ENTRIES];
    word_t  shadow [NUM_WORDS];
    int     tot_reads;
    int     tot_writes;
    int     tot_read_misses;
    int     tot_write_misses;
    int     value_errors;
    int     timeouts;

    dcache_top dcache_top_inst (
        .clk                 (clk),
        .reset               (reset),
        .core_req_valid_i    (core_req_valid),
        .core_req_ready_o    (core_req_ready),
        .core_req_i          (core_req),
        .core_rsp_valid_o    (core_rsp_valid),
        .core_rsp_o          (core_rsp),
        .mem_req_valid_o     (mem_req_valid),
        .mem_req_ready_i     (mem_req_ready),
        .mem_req_o           (mem_req),
        .mem_rsp_valid_i     (mem_rsp_valid),
        .mem_rsp_line_i      (mem_rsp_line),
        .perf_reads_o        (perf_reads),
        .perf_writes_o       (perf_writes),
        .perf_read_misses_o  (perf_read_misses),
        .perf_write_misses_o (perf_write_misses)
    );

    mem_model mem_inst (
        .clk             (clk),
        .reset           (reset),
        .mem_req_valid_i (mem_req_valid),
        .mem_req_i       (mem_req),
        .mem_req_ready_o (mem_req_ready),
        .mem_rsp_valid_o (mem_rsp_valid),
        .mem_rsp_line_o  (mem_rsp_line)
    );

    always #4 clk = ~clk;

    task automatic load_table();
        //          port  rw    addr      byteen   data          tag   miss  pair
        // first line, then a hit in the same line
        tbl[0]  = '{1'b0, 1'b0, 16'h0010, 4'b0000, 32'h00000000, 4'h1, 1'b1, 1'b0};
        tbl[1]  = '{1'b1, 1'b0, 16'h0013, 4'b0000, 32'h00000000, 4'h2, 1'b0, 1'b0};
        // write hit, then read back the merged word
        tbl[2]  = '{1'b0, 1'b1, 16'h0012, 4'b0101, 32'hdeadbeef, 4'h3, 1'b0, 1'b0};
        tbl[3]  = '{1'b1, 1'b0, 16'h0012, 4'b0000, 32'h00000000, 4'h4, 1'b0, 1'b0};
        // write miss, later read miss sees the bytes from memory
        tbl[4]  = '{1'b1, 1'b1, 16'h0104, 4'b1100, 32'h12345678, 4'h5, 1'b1, 1'b0};
        tbl[5]  = '{1'b0, 1'b0, 16'h0104, 4'b0000, 32'h00000000, 4'h6, 1'b1, 1'b0};
        // three lines of set 8, first one evicted by the victim pointer
        tbl[6]  = '{1'b0, 1'b0, 16'h0020, 4'b0000, 32'h00000000, 4'h7, 1'b1, 1'b0};
        tbl[7]  = '{1'b1, 1'b0, 16'h0061, 4'b0000, 32'h00000000, 4'h8, 1'b1, 1'b0};
        tbl[8]  = '{1'b0, 1'b0, 16'h00a2, 4'b0000, 32'h00000000, 4'h9, 1'b1, 1'b0};
        tbl[9]  = '{1'b1, 1'b0, 16'h0023, 4'b0000, 32'h00000000, 4'ha, 1'b1, 1'b0};
        // both ports at once, two lines of set 0
        tbl[10] = '{1'b0, 1'b0, 16'h0300, 4'b0000, 32'h00000000, 4'hb, 1'b1, 1'b1};
        tbl[11] = '{1'b1, 1'b0, 16'h0400, 4'b0000, 32'h00000000, 4'hc, 1'b1, 1'b0};
        tbl[12] = '{1'b0, 1'b1, 16'h0301, 4'b1111, 32'hcafef00d, 4'hd, 1'b0, 1'b1};
        tbl[13] = '{1'b1, 1'b1, 16'h0402, 4'b0011, 32'h0000beef, 4'he, 1'b0, 1'b0};
        tbl[14] = '{1'b0, 1'b0, 16'h0301, 4'b0000, 32'h00000000, 4'hf, 1'b0, 1'b1};
        tbl[15] = '{1'b1, 1'b0, 16'h0402, 4'b0000, 32'h00000000, 4'h0, 1'b0, 1'b0};
    endtask

    // walk the table over the shadow memory, writes merge per byte enable
    task automatic prepare_expected();
        word_t w;
        for (int a = 0; a < NUM_WORDS; a++) begin
            shadow[a] = word_t'(a) ^ 32'h5a5a0000;
        end
        tot_reads        = 0;
        tot_writes       = 0;
        tot_read_misses  = 0;
        tot_write_misses = 0;
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            w = shadow[tbl[i].addr];
            if (tbl[i].rw) begin
                for (int b = 0; b < `DC_WORD_BYTES; b++) begin
                    if (tbl[i].be[b]) w[b*8 +: 8] = tbl[i].data[b*8 +: 8];
                end
                shadow[tbl[i].addr] = w;
                exp_data[i]         = '0;
                tot_writes++;
                if (tbl[i].miss) tot_write_misses++;
            end else begin
                exp_data[i] = w;
                tot_reads++;
                if (tbl[i].miss) tot_read_misses++;
            end
        end
    endtask

    // one request on its port, then its response on the same port
    task automatic run_entry(input int idx);
        entry_t e;
        int     p;
        int     cycles;
        e = tbl[idx];
        p = int'(e.port);
        core_req[p] = '{addr: e.addr, rw: e.rw, byteen: e.be, data: e.data, tag: e.tag};
        core_req_valid[p] = 1'b1;
        // ready follows buffer occupancy, steady until the next edge
        cycles = 0;
        while (!core_req_ready[p] && cycles < TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!core_req_ready[p]) begin
            $display("Timeout at %0t: port %0d never took entry %0d", $time, p, idx);
            timeouts++;
            core_req_valid[p] = 1'b0;
            return;
        end
        // transfer happens on this edge
        @(posedge clk);
        #1;
        core_req_valid[p] = 1'b0;
        cycles = 0;
        while (!core_rsp_valid[p] && cycles < TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!core_rsp_valid[p]) begin
            $display("Timeout at %0t: no response on port %0d for entry %0d", $time, p, idx);
            timeouts++;
        end else begin
            if (core_rsp.tag != e.tag) begin
                $display("Fail %0t: entry %0d tag %h, expected %h",
                         $time, idx, core_rsp.tag, e.tag);
                value_errors++;
            end
            if (core_rsp.data != exp_data[idx]) begin
                $display("Fail %0t: entry %0d data %h, expected %h",
                         $time, idx, core_rsp.data, exp_data[idx]);
                value_errors++;
            end
        end
    endtask

    task automatic check_counters(input int reads, input int writes,
                                  input int rmiss, input int wmiss);
        if (perf_reads != `DC_PERF_BITS'(reads)) begin
            $display("Fail %0t: read count %0d, expected %0d", $time, perf_reads, reads);
            value_errors++;
        end
        if (perf_writes != `DC_PERF_BITS'(writes)) begin
            $display("Fail %0t: write count %0d, expected %0d", $time, perf_writes, writes);
            value_errors++;
        end
        if (perf_read_misses != `DC_PERF_BITS'(rmiss)) begin
            $display("Fail %0t: read miss count %0d, expected %0d",
                     $time, perf_read_misses, rmiss);
            value_errors++;
        end
        if (perf_write_misses != `DC_PERF_BITS'(wmiss)) begin
            $display("Fail %0t: write miss count %0d, expected %0d",
                     $time, perf_write_misses, wmiss);
            value_errors++;
        end
    endtask

    initial begin
        int    i;
        int    grp;
        int    cycles;
        int    rd_run;
        int    wr_run;
        int    rm_run;
        int    wm_run;
        line_t mem_line;
        word_t mem_word;
        clk   = 1'b0;
        reset = 1'b1;
        for (int p = 0; p < `DC_NUM_REQS; p++) begin
            core_req_valid[p] = 1'b0;
            core_req[p]       = '0;
        end
        value_errors = 0;
        timeouts     = 0;
        load_table();
        prepare_expected();
        repeat (4) @(posedge clk);
        #1;
        reset  = 1'b0;
        rd_run = 0;
        wr_run = 0;
        rm_run = 0;
        wm_run = 0;
        i      = 0;
        while (i < NUM_ENTRIES) begin
            grp = tbl[i].pair ? 2 : 1;
            if (grp == 2) begin
                fork
                    run_entry(i);
                    run_entry(i + 1);
                join
            end else begin
                run_entry(i);
            end
            // running totals, misses taken from the table column
            for (int k = i; k < i + grp; k++) begin
                if (tbl[k].rw) wr_run++;
                else rd_run++;
                if (tbl[k].rw && tbl[k].miss) wm_run++;
                if (!tbl[k].rw && tbl[k].miss) rm_run++;
            end
            check_counters(rd_run, wr_run, rm_run, wm_run);
            i += grp;
        end
        // let queued memory writes drain
        cycles = 0;
        while (mem_req_valid && cycles < TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (mem_req_valid) begin
            $display("Timeout at %0t: memory request queue did not drain", $time);
            timeouts++;
        end
        // write-through, memory contents equal the shadow
        for (int a = 0; a < NUM_WORDS; a++) begin
            mem_line = mem_inst.mem_q[a / `DC_LINE_WORDS];
            mem_word = mem_line[(a % `DC_LINE_WORDS) * `DC_WORD_BITS +: `DC_WORD_BITS];
            if (mem_word != shadow[a]) begin
                $display("Fail %0t: memory word %h holds %h, expected %h",
                         $time, a, mem_word, shadow[a]);
                value_errors++;
            end
        end
        check_counters(tot_reads, tot_writes, tot_read_misses, tot_write_misses);
        $display("errors: %0d wrong values, %0d timeouts", value_errors, timeouts);
        if (value_errors == 0 && timeouts == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+include
design/dcache_pkg.sv
design/elastic_buffer.sv
design/req_arbiter.sv
design/cache_core.sv
design/perf_counters.sv
design/dcache_top.sv
bench/mem_model.sv
bench/dcache_tb.sv

/* Makefile */
TOP := dcache_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -Wno-fatal -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -Wno-fatal -f verilog.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "Verification passed"

clean:
	rm -rf obj_dir
